/* list.f */
+incdir+source
source/cache_dma_pkg.sv
source/word_fifo.sv
source/block_data_mem.sv
source/dma_engine.sv
source/miss_handler.sv
source/cache_dma_top.sv
testbench/tb_cache_dma.sv

/* Bender.yml */
package:
  name: cache_dma

export_include_dirs:
  - source

sources:
  - files:
      - source/cache_dma_pkg.sv
      - source/word_fifo.sv
      - source/block_data_mem.sv
      - source/dma_engine.sv
      - source/miss_handler.sv
      - source/cache_dma_top.sv
  - target: test
    files:
      - testbench/tb_cache_dma.sv

/* testbench/tb_cache_dma.sv */
// testbench for the cache slice; models outside memory and checks lookups against a flat word model
`timescale 1ns/100ps
`include "cache_dma_params.svh"

module tb_cache_dma;

  localparam int WAIT_LIMIT = 1000;

  logic clk_i;
  logic reset_i;
  logic lookup_v_i;
  logic lookup_write_i;
  logic [`CACHE_ADDR_WIDTH-1:0] lookup_addr_i;
  logic [`CACHE_DATA_WIDTH-1:0] lookup_data_i;
  logic lookup_ready_o;
  logic resp_v_o;
  logic [`CACHE_DATA_WIDTH-1:0] resp_data_o;
  logic mem_pkt_v_o;
  cache_dma_pkg::mem_op_e mem_pkt_op_o;
  logic [`CACHE_ADDR_WIDTH-1:0] mem_pkt_addr_o;
  logic mem_pkt_yumi_i;
  logic mem_wdata_v_o;
  logic [`CACHE_DATA_WIDTH-1:0] mem_wdata_o;
  logic mem_wdata_yumi_i;
  logic mem_rdata_v_i;
  logic [`CACHE_DATA_WIDTH-1:0] mem_rdata_i;
  logic mem_rdata_ready_o;

  // outside memory contents and the flat reference copy
  logic [`CACHE_DATA_WIDTH-1:0] ext_mem [logic [`CACHE_ADDR_WIDTH-1:0]];
  logic [`CACHE_DATA_WIDTH-1:0] ref_mem [logic [`CACHE_ADDR_WIDTH-1:0]];

  cache_dma_pkg::mem_op_e pkt_op_q [$];
  logic [`CACHE_ADDR_WIDTH-1:0] pkt_addr_q [$];
  logic [`CACHE_DATA_WIDTH-1:0] wdata_q [$];
  logic [`CACHE_DATA_WIDTH-1:0] exp_q [$];
  string test_name = "reset";
  bit mem_busy = 1'b0;
  int error_count = 0;

  cache_dma_top DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic report_failure(input string msg);
    error_count++;
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      report_failure($sformatf("ERR %s expected %h actual %h", name, expected, actual));
    end
  endtask

  // inputs change 2 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk_i);
    #2;
  endtask

  // unwritten words, spread over the whole address
  function automatic logic [31:0] fill_word(input logic [15:0] addr);
    return {addr, ~addr} ^ 32'h5a3c_0f96;
  endfunction

  function automatic logic [31:0] ext_word(input logic [15:0] addr);
    return ext_mem.exists(addr) ? ext_mem[addr] : fill_word(addr);
  endfunction

  function automatic logic [31:0] ref_word(input logic [15:0] addr);
    return ref_mem.exists(addr) ? ref_mem[addr] : fill_word(addr);
  endfunction

  // expected response: the word before the access, loads and stores alike
  function automatic logic [31:0] ref_access(input logic wr, input logic [15:0] addr,
                                             input logic [31:0] data);
    logic [31:0] old;
    old = ref_word(addr);
    if (wr) begin
      ref_mem[addr] = data;
    end
    return old;
  endfunction

  task automatic send_refill_words(input logic [15:0] base);
    int n;
    for (int i = 0; i < `CACHE_BLOCK_WORDS; i++) begin
      repeat ($urandom % 4) next_cycle();
      mem_rdata_v_i = 1'b1;
      mem_rdata_i = ext_word(base + 16'(4 * i));
      n = 0;
      @(posedge clk_i);
      while (!mem_rdata_ready_o) begin
        n++;
        if (n > WAIT_LIMIT) report_failure("refill word was never taken by the DMA engine");
        @(posedge clk_i);
      end
      #2;
      mem_rdata_v_i = 1'b0;
    end
  endtask

  task automatic take_evict_words(input logic [15:0] base);
    int n;
    for (int i = 0; i < `CACHE_BLOCK_WORDS; i++) begin
      n = 0;
      while (!mem_wdata_v_o) begin
        n++;
        if (n > WAIT_LIMIT) report_failure("evict data word never arrived");
        next_cycle();
      end
      repeat ($urandom % 4) next_cycle();
      mem_wdata_yumi_i = 1'b1;
      wdata_q.push_back(mem_wdata_o);
      ext_mem[base + 16'(4 * i)] = mem_wdata_o;
      next_cycle();
      mem_wdata_yumi_i = 1'b0;
    end
  endtask

  // serves one packet at a time, in arrival order
  initial begin : outside_memory
    cache_dma_pkg::mem_op_e op;
    logic [15:0] addr;
    forever begin
      next_cycle();
      if (mem_pkt_v_o) begin
        mem_busy = 1'b1;
        op = mem_pkt_op_o;
        addr = mem_pkt_addr_o;
        repeat ($urandom % 4) next_cycle();
        mem_pkt_yumi_i = 1'b1;
        pkt_op_q.push_back(op);
        pkt_addr_q.push_back(addr);
        next_cycle();
        mem_pkt_yumi_i = 1'b0;
        if (op == cache_dma_pkg::MEM_READ) begin
          send_refill_words(addr);
        end else begin
          take_evict_words(addr);
        end
        mem_busy = 1'b0;
      end
    end
  end

  // responses are sampled mid cycle
  initial begin : compare_responses
    logic [31:0] expected;
    forever begin
      @(negedge clk_i);
      if (resp_v_o) begin
        if (exp_q.size() == 0) begin
          report_failure("a response arrived with no lookup outstanding");
        end else begin
          expected = exp_q.pop_front();
          check_value(test_name, expected, resp_data_o);
        end
      end
    end
  end

  // latency counts edges from acceptance to the response
  task automatic run_lookup(input logic wr, input logic [15:0] addr, input logic [31:0] data,
                            output int latency);
    int n;
    next_cycle();
    lookup_v_i = 1'b1;
    lookup_write_i = wr;
    lookup_addr_i = addr;
    lookup_data_i = data;
    n = 0;
    @(posedge clk_i);
    while (!lookup_ready_o) begin
      n++;
      if (n > WAIT_LIMIT) report_failure("lookup was never accepted");
      @(posedge clk_i);
    end
    exp_q.push_back(ref_access(wr, addr, data));
    #2;
    lookup_v_i = 1'b0;
    latency = 1;
    @(posedge clk_i);
    while (!resp_v_o) begin
      latency++;
      if (latency > WAIT_LIMIT) report_failure("no response for an accepted lookup");
      @(posedge clk_i);
    end
  endtask

  task automatic wait_memory_idle();
    int n;
    n = 0;
    while (mem_busy || mem_pkt_v_o || mem_wdata_v_o) begin
      n++;
      if (n > WAIT_LIMIT) report_failure("outside memory traffic did not drain");
      next_cycle();
    end
  endtask

  task automatic clear_traffic();
    pkt_op_q.delete();
    pkt_addr_q.delete();
    wdata_q.delete();
  endtask

  initial begin
    int lat;
    logic wr;
    logic [15:0] addr;
    logic [31:0] data;
    lookup_v_i = 1'b0;
    lookup_write_i = 1'b0;
    lookup_addr_i = '0;
    lookup_data_i = '0;
    mem_pkt_yumi_i = 1'b0;
    mem_wdata_yumi_i = 1'b0;
    mem_rdata_v_i = 1'b0;
    mem_rdata_i = '0;
    reset_i = 1'b1;
    void'($urandom(97645));
    repeat (8) @(posedge clk_i);
    #2;
    reset_i = 1'b0;
    @(posedge clk_i);
    check_value("reset_lookup_ready", 1, lookup_ready_o);
    check_value("reset_resp_v", 0, resp_v_o);
    check_value("reset_pkt_v", 0, mem_pkt_v_o);
    check_value("reset_wdata_v", 0, mem_wdata_v_o);
    // refill buffer starts empty
    check_value("reset_rdata_ready", 1, mem_rdata_ready_o);

    test_name = "cold_load_miss";
    clear_traffic();
    run_lookup(1'b0, 16'h0124, '0, lat);
    wait_memory_idle();
    check_value("cold_miss_pkt_count", 1, pkt_op_q.size());
    check_value("cold_miss_pkt_op", cache_dma_pkg::MEM_READ, pkt_op_q[0]);
    check_value("cold_miss_pkt_addr", 16'h0120, pkt_addr_q[0]);

    test_name = "load_hit";
    clear_traffic();
    run_lookup(1'b0, 16'h0124, '0, lat);
    check_value("load_hit_latency", 2, lat);
    check_value("load_hit_pkt_count", 0, pkt_op_q.size());

    test_name = "store_then_load";
    run_lookup(1'b1, 16'h0128, 32'hdead_beef, lat);
    check_value("store_hit_latency", 2, lat);
    run_lookup(1'b0, 16'h0128, '0, lat);

    // three blocks in set 2; the stored block goes out second
    test_name = "dirty_eviction";
    clear_traffic();
    run_lookup(1'b0, 16'h01a0, '0, lat);
    wait_memory_idle();
    check_value("empty_victim_pkt_count", 1, pkt_op_q.size());
    clear_traffic();
    run_lookup(1'b0, 16'h0220, '0, lat);
    wait_memory_idle();
    check_value("evict_pkt_count", 2, pkt_op_q.size());
    check_value("evict_refill_op", cache_dma_pkg::MEM_READ, pkt_op_q[0]);
    check_value("evict_refill_addr", 16'h0220, pkt_addr_q[0]);
    check_value("evict_write_op", cache_dma_pkg::MEM_WRITE, pkt_op_q[1]);
    check_value("evict_write_addr", 16'h0120, pkt_addr_q[1]);
    check_value("evict_word_count", `CACHE_BLOCK_WORDS, wdata_q.size());
    for (int i = 0; i < `CACHE_BLOCK_WORDS; i++) begin
      check_value($sformatf("evict_word_%0d", i), ref_word(16'h0120 + 16'(4 * i)), wdata_q[i]);
    end
    clear_traffic();
    run_lookup(1'b0, 16'h02a0, '0, lat);
    wait_memory_idle();
    check_value("clean_victim_pkt_count", 1, pkt_op_q.size());
    check_value("clean_victim_pkt_op", cache_dma_pkg::MEM_READ, pkt_op_q[0]);

    test_name = "random_traffic";
    for (int i = 0; i < 200; i++) begin
      wr = ($urandom % 2) == 1;
      addr = 16'($urandom % 512) & 16'h01fc;
      data = $urandom;
      repeat ($urandom % 3) next_cycle();
      run_lookup(wr, addr, data, lat);
    end

    // two fresh tags per set push every resident block out
    test_name = "flush";
    for (int s = 0; s < `CACHE_SETS; s++) begin
      run_lookup(1'b0, {9'h100, s[2:0], 4'h0}, '0, lat);
      run_lookup(1'b0, {9'h101, s[2:0], 4'h0}, '0, lat);
    end
    wait_memory_idle();
    for (int a = 0; a < 16'h0200; a += 4) begin
      check_value($sformatf("writeback_%h", a[15:0]), ref_word(a[15:0]), ext_word(a[15:0]));
    end

    if (error_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* source/cache_dma_top.sv */
// cache slice top; connects lookup control, DMA engine and the data array to outside memory
`timescale 1ns/100ps
`include "cache_dma_params.svh"

module cache_dma_top (
  input  logic                        clk_i
  , input  logic                        reset_i

  , input  logic                        lookup_v_i
  , input  logic                        lookup_write_i
  , input  logic [`CACHE_ADDR_WIDTH-1:0] lookup_addr_i
  , input  logic [`CACHE_DATA_WIDTH-1:0] lookup_data_i
  , output logic                        lookup_ready_o
  , output logic                        resp_v_o
  , output logic [`CACHE_DATA_WIDTH-1:0] resp_data_o

  , output logic                        mem_pkt_v_o
  , output cache_dma_pkg::mem_op_e      mem_pkt_op_o
  , output logic [`CACHE_ADDR_WIDTH-1:0] mem_pkt_addr_o
  , input  logic                        mem_pkt_yumi_i
  , output logic                        mem_wdata_v_o
  , output logic [`CACHE_DATA_WIDTH-1:0] mem_wdata_o
  , input  logic                        mem_wdata_yumi_i
  , input  logic                        mem_rdata_v_i
  , input  logic [`CACHE_DATA_WIDTH-1:0] mem_rdata_i
  , output logic                        mem_rdata_ready_o
);

  logic dma_cmd_v;
  logic dma_cmd_ready;
  logic dma_cmd_refill;
  logic dma_cmd_evict;
  logic [`CACHE_WAY_WIDTH-1:0] dma_cmd_way;
  logic [`CACHE_INDEX_WIDTH-1:0] dma_cmd_index;
  logic [`CACHE_TAG_WIDTH-1:0] dma_cmd_refill_tag;
  logic [`CACHE_TAG_WIDTH-1:0] dma_cmd_evict_tag;
  logic dma_done;
  logic dma_ack;
  logic dma_pending;

  logic mh_v;
  logic mh_write;
  logic [`CACHE_WAY_WIDTH-1:0] mh_way;
  logic [`CACHE_INDEX_WIDTH-1:0] mh_index;
  logic [`CACHE_OFFSET_WIDTH-1:0] mh_offset;
  logic [`CACHE_DATA_WIDTH-1:0] mh_wdata;
  logic dma_v;
  logic dma_write;
  logic [`CACHE_WAY_WIDTH-1:0] dma_way;
  logic [`CACHE_INDEX_WIDTH-1:0] dma_index;
  logic [`CACHE_OFFSET_WIDTH-1:0] dma_offset;
  logic [`CACHE_DATA_WIDTH-1:0] dma_wdata;
  logic [`CACHE_DATA_WIDTH-1:0] dmem_rdata;

  miss_handler mhu (
    .clk_i(clk_i), .reset_i(reset_i)
    , .lookup_v_i(lookup_v_i), .lookup_write_i(lookup_write_i)
    , .lookup_addr_i(lookup_addr_i), .lookup_data_i(lookup_data_i)
    , .lookup_ready_o(lookup_ready_o), .resp_v_o(resp_v_o), .resp_data_o(resp_data_o)
    , .dma_cmd_v_o(dma_cmd_v), .dma_cmd_refill_o(dma_cmd_refill)
    , .dma_cmd_evict_o(dma_cmd_evict), .dma_cmd_way_o(dma_cmd_way)
    , .dma_cmd_index_o(dma_cmd_index), .dma_cmd_refill_tag_o(dma_cmd_refill_tag)
    , .dma_cmd_evict_tag_o(dma_cmd_evict_tag), .dma_cmd_ready_i(dma_cmd_ready)
    , .dma_done_i(dma_done), .dma_ack_o(dma_ack)
    , .dmem_v_o(mh_v), .dmem_write_o(mh_write), .dmem_way_o(mh_way)
    , .dmem_index_o(mh_index), .dmem_offset_o(mh_offset), .dmem_wdata_o(mh_wdata)
    , .dmem_rdata_i(dmem_rdata)
  );

  dma_engine dma (
    .clk_i(clk_i), .reset_i(reset_i)
    , .dma_cmd_v_i(dma_cmd_v), .dma_cmd_refill_i(dma_cmd_refill)
    , .dma_cmd_evict_i(dma_cmd_evict), .dma_cmd_way_i(dma_cmd_way)
    , .dma_cmd_index_i(dma_cmd_index), .dma_cmd_refill_tag_i(dma_cmd_refill_tag)
    , .dma_cmd_evict_tag_i(dma_cmd_evict_tag), .dma_cmd_ready_o(dma_cmd_ready)
    , .dma_done_o(dma_done), .dma_pending_o(dma_pending), .dma_ack_i(dma_ack)
    , .dmem_v_o(dma_v), .dmem_write_o(dma_write), .dmem_way_o(dma_way)
    , .dmem_index_o(dma_index), .dmem_offset_o(dma_offset), .dmem_wdata_o(dma_wdata)
    , .dmem_rdata_i(dmem_rdata)
    , .mem_pkt_v_o(mem_pkt_v_o), .mem_pkt_op_o(mem_pkt_op_o)
    , .mem_pkt_addr_o(mem_pkt_addr_o), .mem_pkt_yumi_i(mem_pkt_yumi_i)
    , .mem_wdata_v_o(mem_wdata_v_o), .mem_wdata_o(mem_wdata_o)
    , .mem_wdata_yumi_i(mem_wdata_yumi_i)
    , .mem_rdata_v_i(mem_rdata_v_i), .mem_rdata_i(mem_rdata_i)
    , .mem_rdata_ready_o(mem_rdata_ready_o)
  );

  // the engine owns the array while a block move is in flight
  block_data_mem dmem (
    .clk_i(clk_i)
    , .v_i(dma_pending ? dma_v : mh_v)
    , .write_i(dma_pending ? dma_write : mh_write)
    , .way_i(dma_pending ? dma_way : mh_way)
    , .index_i(dma_pending ? dma_index : mh_index)
    , .offset_i(dma_pending ? dma_offset : mh_offset)
    , .data_i(dma_pending ? dma_wdata : mh_wdata)
    , .data_o(dmem_rdata)
  );

endmodule

/* source/miss_handler.sv */
// tag store and lookup control; serves hits and hands misses to the DMA engine
`timescale 1ns/100ps
`include "cache_dma_params.svh"

module miss_handler (
  input  logic                           clk_i
  , input  logic                           reset_i

  , input  logic                           lookup_v_i
  , input  logic                           lookup_write_i
  , input  logic [`CACHE_ADDR_WIDTH-1:0]    lookup_addr_i
  , input  logic [`CACHE_DATA_WIDTH-1:0]    lookup_data_i
  , output logic                           lookup_ready_o
  , output logic                           resp_v_o
  , output logic [`CACHE_DATA_WIDTH-1:0]    resp_data_o

  , output logic                           dma_cmd_v_o
  , output logic                           dma_cmd_refill_o
  , output logic                           dma_cmd_evict_o
  , output logic [`CACHE_WAY_WIDTH-1:0]     dma_cmd_way_o
  , output logic [`CACHE_INDEX_WIDTH-1:0]   dma_cmd_index_o
  , output logic [`CACHE_TAG_WIDTH-1:0]     dma_cmd_refill_tag_o
  , output logic [`CACHE_TAG_WIDTH-1:0]     dma_cmd_evict_tag_o
  , input  logic                           dma_cmd_ready_i
  , input  logic                           dma_done_i
  , output logic                           dma_ack_o

  , output logic                           dmem_v_o
  , output logic                           dmem_write_o
  , output logic [`CACHE_WAY_WIDTH-1:0]     dmem_way_o
  , output logic [`CACHE_INDEX_WIDTH-1:0]   dmem_index_o
  , output logic [`CACHE_OFFSET_WIDTH-1:0]  dmem_offset_o
  , output logic [`CACHE_DATA_WIDTH-1:0]    dmem_wdata_o
  , input  logic [`CACHE_DATA_WIDTH-1:0]    dmem_rdata_i
);

  cache_dma_pkg::mhu_state_e state_r;

  logic [`CACHE_TAG_WIDTH-1:0] tag_r [`CACHE_WAYS][`CACHE_SETS];
  logic [`CACHE_SETS-1:0] valid_r [`CACHE_WAYS];
  logic [`CACHE_SETS-1:0] dirty_r [`CACHE_WAYS];
  logic [`CACHE_SETS-1:0] rr_r;

  logic req_write_r;
  logic [`CACHE_ADDR_WIDTH-1:0] req_addr_r;
  logic [`CACHE_DATA_WIDTH-1:0] req_data_r;
  logic [`CACHE_TAG_WIDTH-1:0] req_tag;
  logic [`CACHE_INDEX_WIDTH-1:0] req_index;

  // lookup_r is the tag check cycle, resp_r the data return cycle
  logic lookup_r;
  logic resp_r;
  logic [`CACHE_WAY_WIDTH-1:0] resp_way_r;
  logic cmd_sent_r;
  logic cmd_evict_r;
  logic [`CACHE_WAY_WIDTH-1:0] cmd_way_r;
  logic [`CACHE_TAG_WIDTH-1:0] cmd_evict_tag_r;

  logic lookup_accept;
  logic hit;
  logic [`CACHE_WAY_WIDTH-1:0] hit_way;
  logic [`CACHE_WAY_WIDTH-1:0] victim_way;

  assign req_tag = req_addr_r[`CACHE_ADDR_WIDTH-1 -: `CACHE_TAG_WIDTH];
  assign req_index = req_addr_r[`CACHE_BLOCK_OFFSET_WIDTH +: `CACHE_INDEX_WIDTH];

  assign lookup_ready_o = (state_r == cache_dma_pkg::READY) & ~lookup_r & ~resp_r;
  assign lookup_accept = lookup_v_i & lookup_ready_o;

  always_comb begin
    hit = 1'b0;
    hit_way = '0;
    victim_way = rr_r[req_index];
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      if (valid_r[w][req_index] && tag_r[w][req_index] == req_tag) begin
        hit = 1'b1;
        hit_way = (`CACHE_WAY_WIDTH)'(w);
      end
    end
    // lowest empty way wins over round robin
    for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
      if (!valid_r[w][req_index]) begin
        victim_way = (`CACHE_WAY_WIDTH)'(w);
      end
    end
  end

  assign resp_v_o = resp_r;
  assign resp_data_o = dmem_rdata_i;

  // read on the check cycle, store writes over the old word one cycle later
  assign dmem_v_o = (lookup_r & hit) | (resp_r & req_write_r);
  assign dmem_write_o = resp_r & req_write_r;
  assign dmem_way_o = resp_r ? resp_way_r : hit_way;
  assign dmem_index_o = req_index;
  assign dmem_offset_o = req_addr_r[`CACHE_BYTE_WIDTH +: `CACHE_OFFSET_WIDTH];
  assign dmem_wdata_o = req_data_r;

  assign dma_cmd_v_o = (state_r == cache_dma_pkg::MISS_WAIT) & ~cmd_sent_r;
  assign dma_cmd_refill_o = 1'b1;
  assign dma_cmd_evict_o = cmd_evict_r;
  assign dma_cmd_way_o = cmd_way_r;
  assign dma_cmd_index_o = req_index;
  assign dma_cmd_refill_tag_o = req_tag;
  assign dma_cmd_evict_tag_o = cmd_evict_tag_r;
  assign dma_ack_o = (state_r == cache_dma_pkg::MISS_WAIT) & cmd_sent_r & dma_done_i;

  always_ff @(posedge clk_i) begin
    if (lookup_accept) begin
      req_write_r <= lookup_write_i;
      req_addr_r <= lookup_addr_i;
      req_data_r <= lookup_data_i;
    end
    if (lookup_r) begin
      resp_way_r <= hit_way;
      cmd_way_r <= victim_way;
      cmd_evict_r <= valid_r[victim_way][req_index] & dirty_r[victim_way][req_index];
      cmd_evict_tag_r <= tag_r[victim_way][req_index];
    end
    if (dma_ack_o) begin
      tag_r[cmd_way_r][req_index] <= req_tag;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= cache_dma_pkg::READY;
      lookup_r <= 1'b0;
      resp_r <= 1'b0;
      cmd_sent_r <= 1'b0;
      rr_r <= '0;
      for (int w = 0; w < `CACHE_WAYS; w++) begin
        valid_r[w] <= '0;
        dirty_r[w] <= '0;
      end
    end else begin
      lookup_r <= lookup_accept | dma_ack_o;
      resp_r <= lookup_r & hit;
      case (state_r)
        cache_dma_pkg::READY: begin
          if (lookup_r && !hit) begin
            state_r <= cache_dma_pkg::MISS_WAIT;
          end
        end
        cache_dma_pkg::MISS_WAIT: begin
          if (dma_cmd_v_o && dma_cmd_ready_i) begin
            cmd_sent_r <= 1'b1;
          end
          if (dma_ack_o) begin
            cmd_sent_r <= 1'b0;
            state_r <= cache_dma_pkg::REPLAY;
            valid_r[cmd_way_r][req_index] <= 1'b1;
            dirty_r[cmd_way_r][req_index] <= 1'b0;
            rr_r[req_index] <= ~cmd_way_r;
          end
        end
        cache_dma_pkg::REPLAY: begin
          if (resp_r) begin
            state_r <= cache_dma_pkg::READY;
          end
        end
        default: state_r <= cache_dma_pkg::READY;
      endcase
      if (resp_r && req_write_r) begin
        dirty_r[resp_way_r][req_index] <= 1'b1;
      end
    end
  end

  // one miss in flight, the engine is idle whenever a command is offered
  assert property (@(posedge clk_i) disable iff (reset_i)
    dma_cmd_v_o |-> dma_cmd_ready_i);

endmodule

/* source/dma_engine.sv */
// moves whole blocks between the data array and outside memory, one miss command at a time
`timescale 1ns/100ps
`include "cache_dma_params.svh"

module dma_engine (
  input  logic                           clk_i
  , input  logic                           reset_i

  // command from the miss handler
  , input  logic                           dma_cmd_v_i
  , input  logic                           dma_cmd_refill_i
  , input  logic                           dma_cmd_evict_i
  , input  logic [`CACHE_WAY_WIDTH-1:0]     dma_cmd_way_i
  , input  logic [`CACHE_INDEX_WIDTH-1:0]   dma_cmd_index_i
  , input  logic [`CACHE_TAG_WIDTH-1:0]     dma_cmd_refill_tag_i
  , input  logic [`CACHE_TAG_WIDTH-1:0]     dma_cmd_evict_tag_i
  , output logic                           dma_cmd_ready_o
  , output logic                           dma_done_o
  , output logic                           dma_pending_o
  , input  logic                           dma_ack_i

  // data array
  , output logic                           dmem_v_o
  , output logic                           dmem_write_o
  , output logic [`CACHE_WAY_WIDTH-1:0]     dmem_way_o
  , output logic [`CACHE_INDEX_WIDTH-1:0]   dmem_index_o
  , output logic [`CACHE_OFFSET_WIDTH-1:0]  dmem_offset_o
  , output logic [`CACHE_DATA_WIDTH-1:0]    dmem_wdata_o
  , input  logic [`CACHE_DATA_WIDTH-1:0]    dmem_rdata_i

  // outside memory
  , output logic                           mem_pkt_v_o
  , output cache_dma_pkg::mem_op_e         mem_pkt_op_o
  , output logic [`CACHE_ADDR_WIDTH-1:0]    mem_pkt_addr_o
  , input  logic                           mem_pkt_yumi_i
  , output logic                           mem_wdata_v_o
  , output logic [`CACHE_DATA_WIDTH-1:0]    mem_wdata_o
  , input  logic                           mem_wdata_yumi_i
  , input  logic                           mem_rdata_v_i
  , input  logic [`CACHE_DATA_WIDTH-1:0]    mem_rdata_i
  , output logic                           mem_rdata_ready_o
);

  cache_dma_pkg::dma_state_e state_r;
  cache_dma_pkg::dma_state_e state_n;

  logic refill_r;
  logic evict_r;
  logic [`CACHE_WAY_WIDTH-1:0] way_r;
  logic [`CACHE_INDEX_WIDTH-1:0] index_r;
  logic [`CACHE_TAG_WIDTH-1:0] refill_tag_r;
  logic [`CACHE_TAG_WIDTH-1:0] evict_tag_r;

  logic [`CACHE_OFFSET_WIDTH-1:0] count_r;
  logic count_up;
  logic count_clear;
  logic count_last;

  logic in_fifo_v;
  logic in_fifo_yumi;
  logic [`CACHE_DATA_WIDTH-1:0] in_fifo_data;
  logic out_fifo_v;
  logic out_fifo_ready;

  logic [`CACHE_ADDR_WIDTH-1:0] refill_addr;
  logic [`CACHE_ADDR_WIDTH-1:0] evict_addr;

  word_fifo in_fifo (
    .clk_i(clk_i)
    , .reset_i(reset_i)
    , .data_i(mem_rdata_i)
    , .v_i(mem_rdata_v_i)
    , .ready_o(mem_rdata_ready_o)
    , .data_o(in_fifo_data)
    , .v_o(in_fifo_v)
    , .yumi_i(in_fifo_yumi)
  );

  // victim words go straight from the array read port
  word_fifo out_fifo (
    .clk_i(clk_i)
    , .reset_i(reset_i)
    , .data_i(dmem_rdata_i)
    , .v_i(out_fifo_v)
    , .ready_o(out_fifo_ready)
    , .data_o(mem_wdata_o)
    , .v_o(mem_wdata_v_o)
    , .yumi_i(mem_wdata_yumi_i)
  );

  assign refill_addr = {refill_tag_r, index_r, {`CACHE_BLOCK_OFFSET_WIDTH{1'b0}}};
  assign evict_addr = {evict_tag_r, index_r, {`CACHE_BLOCK_OFFSET_WIDTH{1'b0}}};
  assign count_last = (count_r == (`CACHE_OFFSET_WIDTH)'(`CACHE_BLOCK_WORDS - 1));

  assign dmem_way_o = way_r;
  assign dmem_index_o = index_r;
  assign dmem_wdata_o = in_fifo_data;

  always_comb begin
    state_n = state_r;
    dma_cmd_ready_o = 1'b0;
    dma_done_o = 1'b0;
    dma_pending_o = 1'b1;
    count_up = 1'b0;
    count_clear = 1'b0;
    out_fifo_v = 1'b0;
    in_fifo_yumi = 1'b0;
    dmem_v_o = 1'b0;
    dmem_write_o = 1'b0;
    dmem_offset_o = count_r;
    mem_pkt_v_o = 1'b0;
    mem_pkt_op_o = cache_dma_pkg::MEM_READ;
    mem_pkt_addr_o = refill_addr;

    case (state_r)
      cache_dma_pkg::IDLE: begin
        dma_pending_o = 1'b0;
        dma_cmd_ready_o = 1'b1;
        if (dma_cmd_v_i) begin
          state_n = dma_cmd_refill_i ? cache_dma_pkg::SEND_REFILL_ADDR
                                     : cache_dma_pkg::SEND_EVICT_ADDR;
        end
      end
      cache_dma_pkg::SEND_REFILL_ADDR: begin
        mem_pkt_v_o = 1'b1;
        if (mem_pkt_yumi_i) begin
          state_n = evict_r ? cache_dma_pkg::SEND_EVICT_ADDR
                            : cache_dma_pkg::RECV_REFILL_DATA;
        end
      end
      cache_dma_pkg::SEND_EVICT_ADDR: begin
        mem_pkt_v_o = 1'b1;
        mem_pkt_op_o = cache_dma_pkg::MEM_WRITE;
        mem_pkt_addr_o = evict_addr;
        // word 0 read lines up with the first push
        dmem_v_o = mem_pkt_yumi_i;
        if (mem_pkt_yumi_i) begin
          state_n = cache_dma_pkg::SEND_EVICT_DATA;
        end
      end
      cache_dma_pkg::SEND_EVICT_DATA: begin
        out_fifo_v = 1'b1;
        if (out_fifo_ready) begin
          if (count_last) begin
            count_clear = 1'b1;
            state_n = refill_r ? cache_dma_pkg::RECV_REFILL_DATA : cache_dma_pkg::DONE;
          end else begin
            // prefetch the next word while this one is pushed
            dmem_v_o = 1'b1;
            dmem_offset_o = count_r + 1'b1;
            count_up = 1'b1;
          end
        end
      end
      cache_dma_pkg::RECV_REFILL_DATA: begin
        dmem_v_o = in_fifo_v;
        dmem_write_o = 1'b1;
        in_fifo_yumi = in_fifo_v;
        if (in_fifo_v) begin
          count_up = ~count_last;
          count_clear = count_last;
          if (count_last) begin
            state_n = cache_dma_pkg::DONE;
          end
        end
      end
      cache_dma_pkg::DONE: begin
        dma_pending_o = 1'b0;
        dma_done_o = 1'b1;
        if (dma_ack_i) begin
          state_n = cache_dma_pkg::IDLE;
        end
      end
      default: begin
        dma_pending_o = 1'b0;
        state_n = cache_dma_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (dma_cmd_v_i && dma_cmd_ready_o) begin
      refill_r <= dma_cmd_refill_i;
      evict_r <= dma_cmd_evict_i;
      way_r <= dma_cmd_way_i;
      index_r <= dma_cmd_index_i;
      refill_tag_r <= dma_cmd_refill_tag_i;
      evict_tag_r <= dma_cmd_evict_tag_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= cache_dma_pkg::IDLE;
      count_r <= '0;
    end else begin
      state_r <= state_n;
      if (count_clear) begin
        count_r <= '0;
      end else if (count_up) begin
        count_r <= count_r + 1'b1;
      end
    end
  end

  assert property (@(posedge clk_i) disable iff (reset_i)
    (mem_pkt_v_o && !mem_pkt_yumi_i) |=>
      (mem_pkt_v_o && $stable(mem_pkt_op_o) && $stable(mem_pkt_addr_o)));

  // every refill word is in the array before done
  assert property (@(posedge clk_i) disable iff (reset_i)
    dma_done_o |-> !(dma_pending_o || in_fifo_v));

endmodule

/* source/block_data_mem.sv */
// single-port cache data array, one word per access, read data registered
`timescale 1ns/100ps
`include "cache_dma_params.svh"

module block_data_mem (
  input  logic                          clk_i

  , input  logic                          v_i
  , input  logic                          write_i
  , input  logic [`CACHE_WAY_WIDTH-1:0]    way_i
  , input  logic [`CACHE_INDEX_WIDTH-1:0]  index_i
  , input  logic [`CACHE_OFFSET_WIDTH-1:0] offset_i
  , input  logic [`CACHE_DATA_WIDTH-1:0]   data_i
  , output logic [`CACHE_DATA_WIDTH-1:0]   data_o
);

  logic [`CACHE_DATA_WIDTH-1:0] mem_r [`CACHE_WAYS*`CACHE_SETS*`CACHE_BLOCK_WORDS];
  logic [`CACHE_WAY_WIDTH+`CACHE_INDEX_WIDTH+`CACHE_OFFSET_WIDTH-1:0] addr;

  // way, then set, then word within the block
  assign addr = {way_i, index_i, offset_i};

  always_ff @(posedge clk_i) begin
    if (v_i) begin
      if (write_i) begin
        mem_r[addr] <= data_i;
      end else begin
        data_o <= mem_r[addr];
      end
    end
  end

endmodule

/* source/word_fifo.sv */
// one-block word buffer between the DMA engine and outside memory, used in both directions
`timescale 1ns/100ps
`include "cache_dma_params.svh"

module word_fifo (
  input  logic                         clk_i
  , input  logic                         reset_i

  , input  logic [`CACHE_DATA_WIDTH-1:0] data_i
  , input  logic                         v_i
  , output logic                         ready_o

  , output logic [`CACHE_DATA_WIDTH-1:0] data_o
  , output logic                         v_o
  , input  logic                         yumi_i
);

  logic [`CACHE_DATA_WIDTH-1:0] mem_r [`CACHE_BLOCK_WORDS];
  logic [`CACHE_OFFSET_WIDTH-1:0] wptr_r;
  logic [`CACHE_OFFSET_WIDTH-1:0] rptr_r;
  logic [`CACHE_OFFSET_WIDTH:0] count_r;
  logic enq;

  assign ready_o = (count_r != `CACHE_BLOCK_WORDS);
  assign v_o = (count_r != '0);
  assign data_o = mem_r[rptr_r];
  assign enq = v_i & ready_o;

  always_ff @(posedge clk_i) begin
    if (enq) begin
      mem_r[wptr_r] <= data_i;
    end
  end

  // pointers wrap naturally, depth is a power of two
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wptr_r <= '0;
      rptr_r <= '0;
      count_r <= '0;
    end else begin
      wptr_r <= wptr_r + (`CACHE_OFFSET_WIDTH)'(enq);
      rptr_r <= rptr_r + (`CACHE_OFFSET_WIDTH)'(yumi_i);
      count_r <= count_r + (`CACHE_OFFSET_WIDTH+1)'(enq) - (`CACHE_OFFSET_WIDTH+1)'(yumi_i);
    end
  end

  assert property (@(posedge clk_i) disable iff (reset_i) yumi_i |-> v_o);

endmodule

/* source/cache_dma_pkg.sv */
// state and opcode types shared by the cache slice modules and the testbench
package cache_dma_pkg;

  // block transfer engine
  typedef enum logic [2:0] {
    IDLE,
    SEND_REFILL_ADDR,
    SEND_EVICT_ADDR,
    SEND_EVICT_DATA,
    RECV_REFILL_DATA,
    DONE
  } dma_state_e;

  // miss handler
  typedef enum logic [1:0] {
    READY,
    MISS_WAIT,
    REPLAY
  } mhu_state_e;

  // outside memory address packet
  typedef enum logic {
    MEM_READ,
    MEM_WRITE
  } mem_op_e;

endpackage

/* source/cache_dma_params.svh */
// cache geometry macros; include in any file that needs address, tag or data widths
`ifndef CACHE_DMA_PARAMS_SVH
`define CACHE_DMA_PARAMS_SVH

// byte address and word size
`define CACHE_ADDR_WIDTH 16
`define CACHE_DATA_WIDTH 32

// organization
`define CACHE_BLOCK_WORDS 4
`define CACHE_SETS 8
`define CACHE_WAYS 2

// derived field widths
`define CACHE_BYTE_WIDTH ($clog2(`CACHE_DATA_WIDTH / 8))
`define CACHE_OFFSET_WIDTH ($clog2(`CACHE_BLOCK_WORDS))
`define CACHE_INDEX_WIDTH ($clog2(`CACHE_SETS))
`define CACHE_WAY_WIDTH ($clog2(`CACHE_WAYS))
`define CACHE_BLOCK_OFFSET_WIDTH (`CACHE_OFFSET_WIDTH + `CACHE_BYTE_WIDTH)
`define CACHE_TAG_WIDTH (`CACHE_ADDR_WIDTH - `CACHE_INDEX_WIDTH - `CACHE_BLOCK_OFFSET_WIDTH)

`endif
